//--- mmu_top.f
+incdir+src
src/mmu_pkg.sv
src/pt_pkg.sv
src/walk_if.sv
src/tlb.sv
src/pt_ram.sv
src/page_table_walker.sv
src/mmu_ctrl.sv
src/mmu_top.sv
tb/tb_mmu_top.sv

//--- Bender.yml
package:
  name: mmu_top

export_include_dirs:
  - src

sources:
  - files:
      - src/mmu_pkg.sv
      - src/pt_pkg.sv
      - src/walk_if.sv
      - src/tlb.sv
      - src/pt_ram.sv
      - src/page_table_walker.sv
      - src/mmu_ctrl.sv
      - src/mmu_top.sv
  - target: test
    files:
      - tb/tb_mmu_top.sv

//--- tb/tb_mmu_top.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tb_mmu_top import pt_pkg::*; ();

  localparam int MAX_CYCLES = 3000;  // About six times the length of all tests
  localparam logic [1:0] LOAD  = 2'd0;
  localparam logic [1:0] STORE = 2'd1;
  localparam logic [1:0] FETCH = 2'd2;

  logic                        clk;
  logic                        rst_n;
  logic                        req_valid_i;
  logic [`MMU_VADDR_WIDTH-1:0] req_vaddr_i;
  logic [1:0]                  req_access_i;
  logic                        req_ready_o;
  logic                        resp_valid_o;
  logic [`MMU_PADDR_WIDTH-1:0] resp_paddr_o;
  logic                        resp_fault_o;
  logic [3:0]                  resp_cause_o;
  logic                        inval_valid_i;
  logic [`MMU_VADDR_WIDTH-1:0] inval_vaddr_i;
  logic                        pt_we_i;
  logic [`MMU_PT_IDX_BITS-1:0] pt_idx_i;
  logic [`MMU_PTE_WIDTH-1:0]   pt_wdata_i;

  // Reference state
  pte_t        pt_model [`MMU_PT_DEPTH];
  logic        tlb_v    [4][2];
  logic [7:0]  tlb_vpn  [4][2];
  logic [11:0] tlb_ppn  [4][2];
  logic [2:0]  tlb_rwx  [4][2];  // {r, w, x}
  logic        tlb_lru  [4];     // Way filled next
  logic [31:0] lcg_state = 32'd40;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          errors_at_start;
  string       cur_test;

  mmu_top u_mmu_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_vaddr_i   (req_vaddr_i),
    .req_access_i  (req_access_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_paddr_o  (resp_paddr_o),
    .resp_fault_o  (resp_fault_o),
    .resp_cause_o  (resp_cause_o),
    .inval_valid_i (inval_valid_i),
    .inval_vaddr_i (inval_vaddr_i),
    .pt_we_i       (pt_we_i),
    .pt_idx_i      (pt_idx_i),
    .pt_wdata_i    (pt_wdata_i)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic pte_t ptr_pte(input logic [3:0] block);
    pte_t p;
    p       = '0;
    p.valid = 1'b1;
    p.ppn   = {8'h00, block};
    return p;
  endfunction

  function automatic pte_t leaf_pte(input logic [11:0] ppn, input logic [2:0] rwx);
    pte_t p;
    p.valid         = 1'b1;
    {p.r, p.w, p.x} = rwx;
    p.ppn           = ppn;
    return p;
  endfunction

  function automatic logic [3:0] cause_for(input logic [1:0] acc);
    case (acc)
      FETCH:   return 4'd12;
      STORE:   return 4'd15;
      default: return 4'd13;
    endcase
  endfunction

  function automatic logic perm_allows(input logic [2:0] rwx, input logic [1:0] acc);
    case (acc)
      FETCH:   return rwx[0];
      STORE:   return rwx[1];
      default: return rwx[2];
    endcase
  endfunction

  // Two-level walk over the reference PTE array
  function automatic logic model_walk(input logic [7:0] vpn, output logic [11:0] ppn,
                                      output logic [2:0] rwx);
    pte_t root;
    pte_t leaf;
    ppn  = '0;
    rwx  = '0;
    root = pt_model[{4'h0, vpn[7:4]}];
    if (!root.valid || root.r || root.w || root.x) return 1'b0;
    leaf = pt_model[{root.ppn[3:0], vpn[3:0]}];
    if (!leaf.valid || !(leaf.r || leaf.w || leaf.x)) return 1'b0;
    ppn = leaf.ppn;
    rwx = {leaf.r, leaf.w, leaf.x};
    return 1'b1;
  endfunction

  task automatic model_access(input logic [19:0] va, input logic [1:0] acc, output logic hit,
                              output logic fault, output logic [3:0] cause,
                              output logic [23:0] pa);
    logic [7:0]  vpn;
    logic [1:0]  set;
    int          way;
    logic [11:0] ppn;
    logic [2:0]  rwx;
    vpn   = va[19:12];
    set   = vpn[1:0];
    hit   = 1'b0;
    way   = 0;
    fault = 1'b1;
    cause = cause_for(acc);
    pa    = '0;
    for (int w = 0; w < 2; w++) begin
      if (tlb_v[set][w] && tlb_vpn[set][w] == vpn) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      if (!model_walk(vpn, ppn, rwx)) return;  // Nothing filled on a walk fault
      way               = tlb_lru[set];
      tlb_v[set][way]   = 1'b1;
      tlb_vpn[set][way] = vpn;
      tlb_ppn[set][way] = ppn;
      tlb_rwx[set][way] = rwx;
    end
    tlb_lru[set] = (way == 0);  // Used way becomes MRU
    fault        = !perm_allows(tlb_rwx[set][way], acc);
    pa           = {tlb_ppn[set][way], va[11:0]};
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic set_pte(input logic [7:0] idx, input pte_t pte);
    pt_model[idx] = pte;
    @(posedge clk);
    pt_we_i    <= 1'b1;
    pt_idx_i   <= idx;
    pt_wdata_i <= pte;
    @(posedge clk);
    pt_we_i <= 1'b0;
  endtask

  task automatic clear_pt_ram();
    for (int i = 0; i < `MMU_PT_DEPTH; i++) begin
      pt_model[i] = '0;
      @(posedge clk);
      pt_we_i    <= 1'b1;
      pt_idx_i   <= i[7:0];
      pt_wdata_i <= '0;
    end
    @(posedge clk);
    pt_we_i <= 1'b0;
  endtask

  task automatic invalidate(input logic [7:0] vpn);
    logic [31:0] rnd;
    rnd = lcg_next();
    for (int w = 0; w < 2; w++) begin
      if (tlb_vpn[vpn[1:0]][w] == vpn) tlb_v[vpn[1:0]][w] = 1'b0;
    end
    @(posedge clk);
    inval_valid_i <= 1'b1;
    inval_vaddr_i <= {vpn, rnd[27:16]};  // Offset must not matter
    @(posedge clk);
    inval_valid_i <= 1'b0;
  endtask

  // One request through the DUT, checked against the reference
  task automatic access_check(input logic [7:0] vpn, input logic [1:0] acc);
    logic [31:0] rnd;
    logic [19:0] va;
    logic        exp_hit;
    logic        exp_fault;
    logic [3:0]  exp_cause;
    logic [23:0] exp_pa;
    int          lat;
    logic        ready_early;
    rnd = lcg_next();
    va  = {vpn, rnd[27:16]};
    model_access(va, acc, exp_hit, exp_fault, exp_cause, exp_pa);
    @(posedge clk);
    req_valid_i  <= 1'b1;
    req_vaddr_i  <= va;
    req_access_i <= acc;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    @(posedge clk);  // Acceptance edge
    req_valid_i <= 1'b0;
    lat         = 1;
    ready_early = 1'b0;
    @(negedge clk);
    while (!resp_valid_o) begin
      if (req_ready_o !== 1'b0) ready_early = 1'b1;  // Only one request in flight
      lat++;
      @(negedge clk);
    end
    checks++;
    if (resp_fault_o !== exp_fault) report_mismatch("fault", exp_fault, resp_fault_o);
    if (exp_fault && resp_cause_o !== exp_cause) report_mismatch("cause", exp_cause, resp_cause_o);
    if (!exp_fault && resp_paddr_o !== exp_pa) report_mismatch("paddr", exp_pa, resp_paddr_o);
    if (req_ready_o !== 1'b1) report_mismatch("ready", 1, req_ready_o);
    if (exp_hit && lat != 1) report_mismatch("hit latency", 1, lat);
    if (!exp_hit && lat <= 1) begin
      $display("%s: vaddr %0h answered without a page-table walk", cur_test, va);
      errors++;
    end
    if (ready_early) begin
      $display("%s: req_ready_o rose before the response to vaddr %0h", cur_test, va);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    $display("%s: finished with %0d errors", cur_test, errors - errors_at_start);
  endtask

  task automatic translate_basic();
    start_test("translate_basic");
    set_pte(8'h01, ptr_pte(4'h1));
    set_pte(8'h02, ptr_pte(4'h2));
    set_pte(8'h10, leaf_pte(12'hA10, 3'b111));  // Leaf index equals VPN here
    set_pte(8'h11, leaf_pte(12'hA11, 3'b111));
    set_pte(8'h23, leaf_pte(12'hB23, 3'b111));
    set_pte(8'h26, leaf_pte(12'hB26, 3'b101));
    repeat (2) begin  // Second round hits
      access_check(8'h10, LOAD);
      access_check(8'h11, STORE);
      access_check(8'h23, FETCH);
      access_check(8'h26, LOAD);
    end
    end_test();
  endtask

  task automatic permission_faults();
    start_test("permission_faults");
    set_pte(8'h03, ptr_pte(4'h3));
    set_pte(8'h30, leaf_pte(12'hC30, 3'b100));  // Read only
    set_pte(8'h31, leaf_pte(12'hC31, 3'b110));  // Read and write
    set_pte(8'h32, leaf_pte(12'hC32, 3'b001));  // Execute only
    repeat (2) begin
      access_check(8'h30, STORE);
      access_check(8'h30, LOAD);
      access_check(8'h31, FETCH);
      access_check(8'h31, STORE);
      access_check(8'h32, LOAD);
      access_check(8'h32, FETCH);
    end
    end_test();
  endtask

  task automatic walk_faults();
    start_test("walk_faults");
    set_pte(8'h05, ptr_pte(4'h5));               // Root 4 stays invalid
    set_pte(8'h51, '0);
    set_pte(8'h52, leaf_pte(12'h052, 3'b000));   // Valid but no permissions
    repeat (2) begin
      access_check(8'h40, LOAD);
      access_check(8'h51, STORE);
      access_check(8'h52, FETCH);
    end
    end_test();
  endtask

  task automatic invalidate_test();
    start_test("invalidate");
    set_pte(8'h06, ptr_pte(4'h6));
    set_pte(8'h60, leaf_pte(12'hC60, 3'b110));
    access_check(8'h60, LOAD);
    set_pte(8'h60, leaf_pte(12'hD60, 3'b110));
    access_check(8'h60, LOAD);  // Stale entry
    invalidate(8'h60);
    access_check(8'h60, LOAD);
    end_test();
  endtask

  task automatic lru_replace();
    start_test("lru_replace");
    set_pte(8'h07, ptr_pte(4'h7));
    set_pte(8'h71, leaf_pte(12'hE71, 3'b111));  // A, B, C all in set 1
    set_pte(8'h75, leaf_pte(12'hE75, 3'b111));
    set_pte(8'h79, leaf_pte(12'hE79, 3'b111));
    access_check(8'h71, LOAD);
    access_check(8'h75, LOAD);
    access_check(8'h71, LOAD);
    access_check(8'h79, LOAD);  // Evicts B
    set_pte(8'h71, leaf_pte(12'hF71, 3'b111));
    set_pte(8'h75, leaf_pte(12'hF75, 3'b111));
    set_pte(8'h79, leaf_pte(12'hF79, 3'b111));
    access_check(8'h71, LOAD);
    access_check(8'h75, LOAD);
    end_test();
  endtask

  initial begin
    rst_n         = 1'b0;
    req_valid_i   = 1'b0;
    req_vaddr_i   = '0;
    req_access_i  = LOAD;
    inval_valid_i = 1'b0;
    inval_vaddr_i = '0;
    pt_we_i       = 1'b0;
    pt_idx_i      = '0;
    pt_wdata_i    = '0;
    for (int s = 0; s < 4; s++) begin
      tlb_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        tlb_v[s][w]   = 1'b0;
        tlb_vpn[s][w] = '0;
        tlb_ppn[s][w] = '0;
        tlb_rwx[s][w] = '0;
      end
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    clear_pt_ram();
    translate_basic();
    permission_faults();
    walk_faults();
    invalidate_test();
    lru_replace();
    $display("Summary: 5 tests, %0d accesses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src/mmu_top.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_top import mmu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid_i,
  input  logic [`MMU_VADDR_WIDTH-1:0] req_vaddr_i,
  input  logic [1:0]                  req_access_i,
  output logic                        req_ready_o,
  output logic                        resp_valid_o,
  output logic [`MMU_PADDR_WIDTH-1:0] resp_paddr_o,
  output logic                        resp_fault_o,
  output logic [3:0]                  resp_cause_o,
  input  logic                        inval_valid_i,
  input  logic [`MMU_VADDR_WIDTH-1:0] inval_vaddr_i,
  input  logic                        pt_we_i,
  input  logic [`MMU_PT_IDX_BITS-1:0] pt_idx_i,
  input  logic [`MMU_PTE_WIDTH-1:0]   pt_wdata_i
);

  mmu_request_t                req;
  logic                        lookup_valid;
  mmu_request_t                lookup_req;
  logic                        tlb_hit;
  logic                        tlb_fault;
  exc_cause_e                  tlb_cause;
  logic [`MMU_PADDR_WIDTH-1:0] tlb_paddr;
  logic                        fill_valid;
  tlb_entry_t                  fill_entry;
  logic                        pt_rd_en;
  logic [`MMU_PT_IDX_BITS-1:0] pt_rd_idx;
  logic [`MMU_PTE_WIDTH-1:0]   pt_rd_data;

  assign req.vaddr  = req_vaddr_i;
  assign req.access = access_e'(req_access_i);

  walk_if u_walk_if ();

  mmu_ctrl u_mmu_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req),
    .req_ready_o    (req_ready_o),
    .lookup_valid_o (lookup_valid),
    .lookup_req_o   (lookup_req),
    .hit_i          (tlb_hit),
    .fault_i        (tlb_fault),
    .cause_i        (tlb_cause),
    .paddr_i        (tlb_paddr),
    .fill_valid_o   (fill_valid),
    .fill_entry_o   (fill_entry),
    .walk           (u_walk_if.ctrl),
    .resp_valid_o   (resp_valid_o),
    .resp_paddr_o   (resp_paddr_o),
    .resp_fault_o   (resp_fault_o),
    .resp_cause_o   (resp_cause_o)
  );

  // Invalidation bypasses the controller
  tlb u_tlb (
    .clk            (clk),
    .rst_n          (rst_n),
    .lookup_valid_i (lookup_valid),
    .lookup_req_i   (lookup_req),
    .hit_o          (tlb_hit),
    .fault_o        (tlb_fault),
    .cause_o        (tlb_cause),
    .paddr_o        (tlb_paddr),
    .fill_valid_i   (fill_valid),
    .fill_entry_i   (fill_entry),
    .inval_valid_i  (inval_valid_i),
    .inval_vaddr_i  (inval_vaddr_i)
  );

  page_table_walker u_page_table_walker (
    .clk       (clk),
    .rst_n     (rst_n),
    .walk      (u_walk_if.walker),
    .rd_en_o   (pt_rd_en),
    .rd_idx_o  (pt_rd_idx),
    .rd_data_i (pt_rd_data)
  );

  pt_ram u_pt_ram (
    .clk       (clk),
    .rd_en_i   (pt_rd_en),
    .rd_idx_i  (pt_rd_idx),
    .rd_data_o (pt_rd_data),
    .wr_en_i   (pt_we_i),
    .wr_idx_i  (pt_idx_i),
    .wr_data_i (pt_wdata_i)
  );

endmodule

//--- src/mmu_ctrl.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_ctrl import mmu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid_i,
  input  mmu_request_t                req_i,
  output logic                        req_ready_o,
  output logic                        lookup_valid_o,
  output mmu_request_t                lookup_req_o,
  input  logic                        hit_i,
  input  logic                        fault_i,
  input  exc_cause_e                  cause_i,
  input  logic [`MMU_PADDR_WIDTH-1:0] paddr_i,
  output logic                        fill_valid_o,
  output tlb_entry_t                  fill_entry_o,
  walk_if.ctrl                        walk,
  output logic                        resp_valid_o,
  output logic [`MMU_PADDR_WIDTH-1:0] resp_paddr_o,
  output logic                        resp_fault_o,
  output exc_cause_e                  resp_cause_o
);

  typedef enum logic [1:0] {S_IDLE, S_WALK, S_REPLAY} ctrl_state_e;

  ctrl_state_e  state_q;
  mmu_request_t req_q;
  logic         accept;
  logic         take_lookup;   // Response comes from the TLB this cycle
  logic         walk_fault;

  assign req_ready_o = (state_q == S_IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign take_lookup = (accept && hit_i) || (state_q == S_REPLAY);
  assign walk_fault  = (state_q == S_WALK) && walk.done && walk.fault;

  assign lookup_valid_o = accept || (state_q == S_REPLAY);
  assign lookup_req_o   = (state_q == S_REPLAY) ? req_q : req_i;

  // Miss starts the walk in the acceptance cycle
  assign walk.start = accept && !hit_i;
  assign walk.vaddr = req_i.vaddr;

  assign fill_valid_o = (state_q == S_WALK) && walk.done && !walk.fault;
  assign fill_entry_o = walk.entry;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= S_IDLE;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= take_lookup || walk_fault;
      case (state_q)
        S_IDLE:   if (accept && !hit_i) state_q <= S_WALK;
        S_WALK:   if (walk.done) state_q <= walk.fault ? S_IDLE : S_REPLAY;
        S_REPLAY: state_q <= S_IDLE;
        default:  state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) req_q <= req_i;
    if (take_lookup) begin
      resp_paddr_o <= paddr_i;
      resp_fault_o <= fault_i || !hit_i;
      resp_cause_o <= cause_i;
    end else if (walk_fault) begin
      resp_paddr_o <= '0;
      resp_fault_o <= 1'b1;
      resp_cause_o <= fault_cause(req_q.access);
    end
  end

endmodule

//--- src/page_table_walker.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module page_table_walker import mmu_pkg::*, pt_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  walk_if.walker                      walk,
  output logic                        rd_en_o,
  output logic [`MMU_PT_IDX_BITS-1:0] rd_idx_o,
  input  pte_t                        rd_data_i
);

  localparam int LB    = `MMU_PT_LEVEL_BITS;
  localparam int IDX_W = `MMU_PT_IDX_BITS;
  localparam int VPN_W = `MMU_VPN_WIDTH;

  walk_state_e      state_q;
  walk_state_e      state_d;
  logic [VPN_W-1:0] vpn_q;
  logic [LB-1:0]    ptr_q;    // Block of the level-2 table
  logic             fault_q;
  tlb_entry_t       entry_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE:    if (walk.start) state_d = W_L1_READ;
      W_L1_READ: state_d = W_L1_WAIT;
      W_L1_WAIT: state_d = pte_is_pointer(rd_data_i) ? W_L2_READ : W_DONE;
      W_L2_READ: state_d = W_L2_WAIT;
      W_L2_WAIT: state_d = W_DONE;
      W_DONE:    state_d = W_IDLE;
      default:   state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= W_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Walk context and result
  always_ff @(posedge clk) begin
    if (state_q == W_IDLE && walk.start) begin
      vpn_q <= walk.vaddr[`MMU_VADDR_WIDTH-1 -: VPN_W];
    end
    if (state_q == W_L1_WAIT) begin
      ptr_q   <= rd_data_i.ppn[LB-1:0];
      fault_q <= !pte_is_pointer(rd_data_i);
    end
    if (state_q == W_L2_WAIT) begin
      fault_q       <= !pte_is_leaf(rd_data_i);
      entry_q.valid <= 1'b1;
      entry_q.vpn   <= vpn_q;
      entry_q.ppn   <= rd_data_i.ppn;
      entry_q.r     <= rd_data_i.r;
      entry_q.w     <= rd_data_i.w;
      entry_q.x     <= rd_data_i.x;
    end
  end

  assign rd_en_o  = (state_q == W_L1_READ) || (state_q == W_L2_READ);
  // Root table sits in the first block
  assign rd_idx_o = (state_q == W_L2_READ) ? {ptr_q, vpn_q[LB-1:0]}
                                           : {(IDX_W-LB)'(0), vpn_q[VPN_W-1 -: LB]};

  assign walk.done  = (state_q == W_DONE);
  assign walk.fault = fault_q;
  assign walk.entry = entry_q;

endmodule

//--- src/pt_ram.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module pt_ram import pt_pkg::*; (
  input  logic                        clk,
  // Walker read port
  input  logic                        rd_en_i,
  input  logic [`MMU_PT_IDX_BITS-1:0] rd_idx_i,
  output pte_t                        rd_data_o,
  // Software write port
  input  logic                        wr_en_i,
  input  logic [`MMU_PT_IDX_BITS-1:0] wr_idx_i,
  input  pte_t                        wr_data_i
);

  pte_t mem [`MMU_PT_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_idx_i] <= wr_data_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_idx_i];
    end
  end

endmodule

//--- src/tlb.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tlb import mmu_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        lookup_valid_i,
  input  mmu_request_t                lookup_req_i,
  output logic                        hit_o,
  output logic                        fault_o,
  output exc_cause_e                  cause_o,
  output logic [`MMU_PADDR_WIDTH-1:0] paddr_o,
  input  logic                        fill_valid_i,
  input  tlb_entry_t                  fill_entry_i,
  input  logic                        inval_valid_i,
  input  logic [`MMU_VADDR_WIDTH-1:0] inval_vaddr_i
);

  localparam int ASSOC    = `MMU_TLB_ASSOC;
  localparam int NUM_SETS = `MMU_TLB_SIZE / `MMU_TLB_ASSOC;
  localparam int SET_BITS = $clog2(NUM_SETS);
  localparam int WAY_BITS = $clog2(ASSOC);
  localparam int VPN_W    = `MMU_VPN_WIDTH;
  localparam int TAG_BITS = VPN_W - SET_BITS;
  localparam int PAGE     = `MMU_PAGE_BITS;

  tlb_entry_t          entry_q [NUM_SETS][ASSOC];
  logic [ASSOC-1:0]    valid_q [NUM_SETS];
  logic [WAY_BITS-1:0] lru_q   [NUM_SETS];  // Way to replace next

  logic [SET_BITS-1:0] lk_set;
  logic [TAG_BITS-1:0] lk_tag;
  logic [SET_BITS-1:0] inv_set;
  logic [TAG_BITS-1:0] inv_tag;
  logic [SET_BITS-1:0] fill_set;
  logic [ASSOC-1:0]    lk_match;
  logic [ASSOC-1:0]    inv_match;
  logic [WAY_BITS-1:0] hit_way;
  tlb_entry_t          hit_entry;
  logic                perm_ok;

  assign lk_set   = lookup_req_i.vaddr[PAGE +: SET_BITS];
  assign lk_tag   = lookup_req_i.vaddr[`MMU_VADDR_WIDTH-1 -: TAG_BITS];
  assign inv_set  = inval_vaddr_i[PAGE +: SET_BITS];
  assign inv_tag  = inval_vaddr_i[`MMU_VADDR_WIDTH-1 -: TAG_BITS];
  assign fill_set = fill_entry_i.vpn[SET_BITS-1:0];

  // Tag compare for lookup and invalidation
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < ASSOC; w++) begin
      lk_match[w]  = valid_q[lk_set][w] &&
                     (entry_q[lk_set][w].vpn[VPN_W-1 -: TAG_BITS] == lk_tag);
      inv_match[w] = valid_q[inv_set][w] &&
                     (entry_q[inv_set][w].vpn[VPN_W-1 -: TAG_BITS] == inv_tag);
      if (lk_match[w]) hit_way = WAY_BITS'(w);
    end
  end

  assign hit_entry = entry_q[lk_set][hit_way];
  assign hit_o     = |lk_match;

  // Fetch needs X, store needs W, load needs R
  always_comb begin
    case (lookup_req_i.access)
      ACC_FETCH: perm_ok = hit_entry.x;
      ACC_STORE: perm_ok = hit_entry.w;
      default:   perm_ok = hit_entry.r;
    endcase
  end

  assign fault_o = hit_o && !perm_ok;
  assign cause_o = fault_cause(lookup_req_i.access);
  assign paddr_o = {hit_entry.ppn, lookup_req_i.vaddr[PAGE-1:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        lru_q[s]   <= '0;
      end
    end else begin
      if (lookup_valid_i && hit_o) begin
        lru_q[lk_set] <= ~hit_way;  // Other way becomes LRU
      end
      if (fill_valid_i) begin
        valid_q[fill_set][lru_q[fill_set]] <= fill_entry_i.valid;
        lru_q[fill_set] <= ~lru_q[fill_set];
      end
      if (inval_valid_i) begin
        valid_q[inv_set] <= valid_q[inv_set] & ~inv_match;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (fill_valid_i) begin
      entry_q[fill_set][lru_q[fill_set]] <= fill_entry_i;
    end
  end

endmodule

//--- src/walk_if.sv
`timescale 1ns/100ps
`include "mmu_consts.svh"

interface walk_if import mmu_pkg::*; ();

  logic                        start;  // One-cycle pulse, walker idle
  logic [`MMU_VADDR_WIDTH-1:0] vaddr;
  logic                        done;   // One-cycle pulse
  logic                        fault;
  tlb_entry_t                  entry;  // Valid with done when no fault

  modport ctrl (
    output start,
    output vaddr,
    input  done,
    input  fault,
    input  entry
  );

  modport walker (
    input  start,
    input  vaddr,
    output done,
    output fault,
    output entry
  );

endinterface

//--- src/pt_pkg.sv
`include "mmu_consts.svh"

package pt_pkg;

  typedef struct packed {
    logic                      valid;
    logic                      r;
    logic                      w;
    logic                      x;
    logic [`MMU_PPN_WIDTH-1:0] ppn;  // Low bits pick the next table block
  } pte_t;

  typedef enum logic [2:0] {
    W_IDLE,
    W_L1_READ,
    W_L1_WAIT,
    W_L2_READ,
    W_L2_WAIT,
    W_DONE
  } walk_state_e;

  // Valid with no permissions means pointer to next level
  function automatic logic pte_is_pointer(pte_t pte);
    return pte.valid && !pte.r && !pte.w && !pte.x;
  endfunction

  function automatic logic pte_is_leaf(pte_t pte);
    return pte.valid && (pte.r || pte.w || pte.x);
  endfunction

endpackage

//--- src/mmu_pkg.sv
`include "mmu_consts.svh"

package mmu_pkg;

  typedef enum logic [1:0] {
    ACC_LOAD  = 2'd0,
    ACC_STORE = 2'd1,
    ACC_FETCH = 2'd2
  } access_e;

  typedef struct packed {
    logic [`MMU_VADDR_WIDTH-1:0] vaddr;
    access_e                     access;
  } mmu_request_t;

  typedef struct packed {
    logic                      valid;
    logic [`MMU_VPN_WIDTH-1:0] vpn;   // Full VPN, tag is the upper part
    logic [`MMU_PPN_WIDTH-1:0] ppn;
    logic                      r;
    logic                      w;
    logic                      x;
  } tlb_entry_t;

  typedef enum logic [3:0] {
    EXC_INSTR_PAGE_FAULT = 4'd12,
    EXC_LOAD_PAGE_FAULT  = 4'd13,
    EXC_STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // Page fault cause for a given access kind
  function automatic exc_cause_e fault_cause(access_e acc);
    case (acc)
      ACC_FETCH: return EXC_INSTR_PAGE_FAULT;
      ACC_STORE: return EXC_STORE_PAGE_FAULT;
      default:   return EXC_LOAD_PAGE_FAULT;
    endcase
  endfunction

endpackage

//--- src/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// Address space
`define MMU_VADDR_WIDTH   20
`define MMU_PADDR_WIDTH   24
`define MMU_PAGE_BITS     12   // 4 KiB pages
`define MMU_VPN_WIDTH     (`MMU_VADDR_WIDTH - `MMU_PAGE_BITS)
`define MMU_PPN_WIDTH     (`MMU_PADDR_WIDTH - `MMU_PAGE_BITS)

// TLB geometry
`define MMU_TLB_SIZE      8
`define MMU_TLB_ASSOC     2

// Page-table RAM
`define MMU_PT_DEPTH      256
`define MMU_PT_IDX_BITS   8
`define MMU_PT_LEVEL_BITS 4    // VPN bits resolved per walk level
`define MMU_PTE_WIDTH     16

`endif
